// File: src.f
+incdir+include
src/tc_geom_pkg.sv
src/tc_types_pkg.sv
src/instr_scan_reg.sv
src/port_decode.sv
src/openram_testchip.sv
verif/tb_openram_testchip.sv

// File: run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=sim_tb
LOG=sim.log

verilator --binary --timing --assert \
	--top-module tb_openram_testchip \
	-f src.f \
	--Mdir "$BUILD_DIR" \
	-o "$SIM_BIN"
status=$?
if [ $status -ne 0 ]; then
	echo "build failed with status $status"
	exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "sim passed" "$LOG"; then
	exit 0
else
	echo "pass message not found in $LOG"
	exit 1
fi

// File: include/tb_vectors.svh
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// one stimulus row, inputs held for n_cyc clocks
typedef struct packed {
	logic [7:0] n_cyc;       // TOTAL_W for a full scan, gpio_in_i takes word msb first
	logic       scan;
	logic       load;
	logic       gpio_cap;
	logic       la_cap;
	logic       global_csb;
	reg_op_e    exp_op;      // update the register must make
	instr_t     word;        // la_data_i value or the scanned word
} tb_vec_t;

// both ports enabled on bank 3
localparam instr_t TB_WORD_A = '{sel: 4'd3,
	port0: '{addr: 16'h0a5c, din: 32'h1357_9bdf, en: 1'b1, web: 1'b0, wmask: 4'hf},
	port1: '{addr: 16'h00f3, din: 32'h2468_ace0, en: 1'b1, web: 1'b1, wmask: 4'h0}};
// rom bank, read only
localparam instr_t TB_WORD_R = '{sel: 4'd11,
	port0: '{addr: 16'h0301, din: 32'h0bad_cafe, en: 1'b1, web: 1'b1, wmask: 4'h0},
	port1: '{addr: 16'h0302, din: 32'hffff_0000, en: 1'b1, web: 1'b1, wmask: 4'h0}};
// scanned in on bank 7
localparam instr_t TB_WORD_B = '{sel: 4'd7,
	port0: '{addr: 16'hc33c, din: 32'h8000_0001, en: 1'b1, web: 1'b1, wmask: 4'h5},
	port1: '{addr: 16'h1e1e, din: 32'h5a5a_a5a5, en: 1'b1, web: 1'b0, wmask: 4'ha}};
// port0 off, port1 on bank 14
localparam instr_t TB_WORD_C = '{sel: 4'd14,
	port0: '{addr: 16'h7777, din: 32'h0f0f_0f0f, en: 1'b0, web: 1'b0, wmask: 4'h3},
	port1: '{addr: 16'h0042, din: 32'h1111_2222, en: 1'b1, web: 1'b1, wmask: 4'hc}};

localparam int TB_N_VECS = 10;

localparam tb_vec_t TB_VECS [TB_N_VECS] = '{
	'{8'd1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, OP_LOAD, TB_WORD_A},        // parallel load
	'{8'd1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, OP_HOLD, TB_WORD_A},        // global csb off
	'{8'd1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, OP_HOLD, TB_WORD_A},        // decode back
	'{8'd1, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, OP_CAPTURE, TB_WORD_A},     // gpio capture
	'{8'd1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, OP_LOAD, TB_WORD_R},        // rom bank
	'{8'd1, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, OP_CAPTURE, TB_WORD_R},     // la capture
	'{8'd112, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, OP_SHIFT, TB_WORD_B},     // full scan
	'{8'd1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, OP_SHIFT, TB_WORD_A},       // scan beats load
	'{8'd1, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0, OP_LOAD, TB_WORD_C},        // load beats capture
	'{8'd1, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, OP_CAPTURE, TB_WORD_C}      // port1 only
};

`endif

// File: verif/tb_openram_testchip.sv
`timescale 1ns/10ps

module tb_openram_testchip
	import tc_geom_pkg::*;
	import tc_types_pkg::*;
();

	`include "tb_vectors.svh"

	localparam int HALF_PERIOD  = 50;  // 100 ns clock
	localparam int RESET_CYC    = 16;
	localparam int WATCHDOG_CYC = TB_N_VECS + TOTAL_W + 40;

	logic               clk = 1'b0;
	logic               resetn;
	logic               gpio_in;
	logic               gpio_scan;
	logic               la_in_load;
	instr_t             la_data_in;
	logic               gpio_sram_load;
	logic               la_sram_load;
	logic               global_csb;
	bank_rd_t           bank_rd [N_BANKS];  // fixed for the whole run
	port_req_t          port0;
	port_req_t          port1;
	logic [N_BANKS-1:0] csb0;
	logic [N_BANKS-1:0] csb1;
	instr_t             la_data_out;
	logic               gpio_out;

	instr_t model;      // expected register contents
	int     err_cnt;
	int     fail_rows;

	always #HALF_PERIOD clk = ~clk;

	openram_testchip openram_testchip_inst (
		.clk              (clk),
		.resetn           (resetn),
		.gpio_in_i        (gpio_in),
		.gpio_scan_i      (gpio_scan),
		.la_in_load_i     (la_in_load),
		.la_data_i        (la_data_in),
		.gpio_sram_load_i (gpio_sram_load),
		.la_sram_load_i   (la_sram_load),
		.global_csb_i     (global_csb),
		.bank_rd_i        (bank_rd),
		.port0_o          (port0),
		.port1_o          (port1),
		.csb0_o           (csb0),
		.csb1_o           (csb1),
		.la_data_o        (la_data_out),
		.gpio_out_o       (gpio_out)
	);

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic string op_label(input reg_op_e op);
		case (op)
			OP_SHIFT:   return "shift";
			OP_LOAD:    return "load";
			OP_CAPTURE: return "capture";
			default:    return "hold";
		endcase
	endfunction

	// bank sel low only for an enabled port while global csb is low
	function automatic logic [N_BANKS-1:0] expect_csb(input logic en,
		input logic [SEL_W-1:0] sel, input logic off);
		logic [N_BANKS-1:0] csb;
		csb = '1;
		if (en && !off) begin
			csb[sel] = 1'b0;
		end
		return csb;
	endfunction

	// register contents after one edge with the row's command applied
	function automatic instr_t next_state(input instr_t cur, input tb_vec_t v, input logic b);
		instr_t   nxt;
		bank_rd_t rd;
		nxt = cur;
		rd  = bank_rd[cur.sel];
		case (v.exp_op)
			OP_SHIFT: nxt = {cur[TOTAL_W-2:0], b};  // new bit at lsb
			OP_LOAD:  nxt = v.word;
			OP_CAPTURE: begin
				nxt.port0.din = rd.rd0;
				nxt.port1.din = (cur.sel == SEL_W'(ROM_BANK)) ? '0 : rd.rd1;  // rom rd1 reads 0
			end
			default:  nxt = cur;
		endcase
		return nxt;
	endfunction

	task automatic drive_row(input tb_vec_t v, input logic b);
		gpio_in        <= b;
		gpio_scan      <= v.scan;
		la_in_load     <= v.load;
		la_data_in     <= v.word;
		gpio_sram_load <= v.gpio_cap;
		la_sram_load   <= v.la_cap;
		global_csb     <= v.global_csb;
	endtask

	task automatic idle_inputs();
		gpio_in        <= 1'b0;
		gpio_scan      <= 1'b0;
		la_in_load     <= 1'b0;
		gpio_sram_load <= 1'b0;
		la_sram_load   <= 1'b0;  // global csb and la data stay as they were
	endtask

	task automatic check_outputs(input int row);
		logic [N_BANKS-1:0] exp_csb0;
		logic [N_BANKS-1:0] exp_csb1;
		exp_csb0 = expect_csb(model.port0.en, model.sel, global_csb);
		exp_csb1 = expect_csb(model.port1.en, model.sel, global_csb);
		assert (la_data_out === model) else begin
			$display("ERR %0t: row %0d la_data_o %h, expected %h", $time, row, la_data_out, model);
			err_cnt++;
		end
		assert (gpio_out === model[TOTAL_W-1]) else begin
			$display("ERR %0t: row %0d gpio_out_o %b, expected %b", $time, row, gpio_out,
				model[TOTAL_W-1]);
			err_cnt++;
		end
		assert (port0 === model.port0 && port1 === model.port1) else begin
			$display("ERR %0t: row %0d port fields %h %h, expected %h %h", $time, row,
				port0, port1, model.port0, model.port1);
			err_cnt++;
		end
		assert (csb0 === exp_csb0 && csb1 === exp_csb1) else begin
			$display("ERR %0t: row %0d csb %h %h, expected %h %h", $time, row, csb0, csb1,
				exp_csb0, exp_csb1);
			err_cnt++;
		end
	endtask

	initial begin
		logic [31:0] seed;
		tb_vec_t     v;
		logic        bit_in;
		int          row_err;
		seed = 32'h26ad_62ac;
		for (int i = 0; i < N_BANKS; i++) begin
			seed = lcg_next(seed);
			bank_rd[i].rd0 = seed;
			seed = lcg_next(seed);
			bank_rd[i].rd1 = seed;
		end
		resetn         = 1'b0;
		gpio_in        = 1'b0;
		gpio_scan      = 1'b0;
		la_in_load     = 1'b0;
		la_data_in     = '0;
		gpio_sram_load = 1'b0;
		la_sram_load   = 1'b0;
		global_csb     = 1'b0;
		model          = '0;  // reset value
		err_cnt        = 0;
		fail_rows      = 0;
		bit_in         = 1'b0;
		repeat (RESET_CYC) @(posedge clk);
		resetn <= 1'b1;
		for (int r = 0; r < TB_N_VECS; r++) begin
			v       = TB_VECS[r];
			row_err = err_cnt;
			for (int c = 0; c < int'(v.n_cyc); c++) begin
				@(posedge clk);
				if (c > 0) begin
					model = next_state(model, v, bit_in);  // edge took last cycle's command
				end
				bit_in = v.word[TOTAL_W-1-c];  // scan order is msb first
				drive_row(v, bit_in);
				@(negedge clk);
				check_outputs(r);  // first pass of row 0 covers reset state
			end
			@(posedge clk);
			model = next_state(model, v, bit_in);
			idle_inputs();
			@(negedge clk);
			check_outputs(r);
			if (v.exp_op == OP_SHIFT && int'(v.n_cyc) == TOTAL_W) begin
				assert (la_data_out === v.word) else begin
					$display("ERR %0t: row %0d scanned word %h, expected %h", $time, r,
						la_data_out, v.word);
					err_cnt++;
				end
			end
			if (err_cnt != row_err) begin
				fail_rows++;
			end
			$display("row %0d %s: %s", r, op_label(v.exp_op), (err_cnt == row_err) ? "ok" : "FAILED");
		end
		$display("%0d rows run, %0d failed, %0d check errors", TB_N_VECS, fail_rows, err_cnt);
		if (err_cnt == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

	// rows plus one full scan plus slack for reset and idle cycles
	initial begin
		#(WATCHDOG_CYC * 2 * HALF_PERIOD);
		$display("timeout: run did not complete within %0d clock periods", WATCHDOG_CYC);
		$display("sim failed");
		$finish;
	end

endmodule

// File: src/openram_testchip.sv
`timescale 1ns/10ps

module openram_testchip
	import tc_geom_pkg::*;
	import tc_types_pkg::*;
(
	input  logic               clk,
	input  logic               resetn,
	// serial path
	input  logic               gpio_in_i,
	input  logic               gpio_scan_i,
	// parallel path
	input  logic               la_in_load_i,
	input  instr_t             la_data_i,
	// capture requests
	input  logic               gpio_sram_load_i,
	input  logic               la_sram_load_i,
	input  logic               global_csb_i,
	input  bank_rd_t           bank_rd_i [N_BANKS],  // dout of every bank
	// shared sram pins, en is not routed to the macros
	output port_req_t          port0_o,
	output port_req_t          port1_o,
	output logic [N_BANKS-1:0] csb0_o,
	output logic [N_BANKS-1:0] csb1_o,
	// read-back
	output instr_t             la_data_o,
	output logic               gpio_out_o
);

	logic   capture;
	instr_t instr;

	assign capture = gpio_sram_load_i | la_sram_load_i;  // either side may capture

	instr_scan_reg instr_scan_reg_inst (
		.clk          (clk),
		.resetn       (resetn),
		.gpio_in_i    (gpio_in_i),
		.gpio_scan_i  (gpio_scan_i),
		.la_in_load_i (la_in_load_i),
		.la_data_i    (la_data_i),
		.capture_i    (capture),
		.bank_rd_i    (bank_rd_i),
		.instr_o      (instr)
	);

	port_decode port_decode_inst (
		.instr_i      (instr),
		.global_csb_i (global_csb_i),
		.port0_o      (port0_o),
		.port1_o      (port1_o),
		.csb0_o       (csb0_o),
		.csb1_o       (csb1_o)
	);

	assign la_data_o  = instr;
	assign gpio_out_o = instr[TOTAL_W-1];  // scan out msb first

endmodule

// File: src/port_decode.sv
`timescale 1ns/10ps

module port_decode
	import tc_geom_pkg::*;
	import tc_types_pkg::*;
(
	input  instr_t             instr_i,
	input  logic               global_csb_i,  // high forces every bank off
	output port_req_t          port0_o,
	output port_req_t          port1_o,
	output logic [N_BANKS-1:0] csb0_o,
	output logic [N_BANKS-1:0] csb1_o
);

	// active low select, one bank at most
	function automatic logic [N_BANKS-1:0] bank_csb(
		input logic             sel_en,
		input logic [SEL_W-1:0] sel
	);
		logic [N_BANKS-1:0] act;
		act = '0;
		act[sel] = sel_en;
		return ~act;
	endfunction

	// shared address, data, web and mask pins
	assign port0_o = instr_i.port0;
	assign port1_o = instr_i.port1;

	// both ports aim at the same bank, each gated by its own enable
	assign csb0_o = bank_csb(instr_i.port0.en & ~global_csb_i, instr_i.sel);
	assign csb1_o = bank_csb(instr_i.port1.en & ~global_csb_i, instr_i.sel);

	// never two banks driven from one port
	always_comb begin
		ap_csb0_onehot: assert ($onehot0(~csb0_o))
			else $error("csb0_o has more than one bank selected");
		ap_csb1_onehot: assert ($onehot0(~csb1_o))
			else $error("csb1_o has more than one bank selected");
	end

endmodule

// File: src/instr_scan_reg.sv
`timescale 1ns/10ps

module instr_scan_reg
	import tc_geom_pkg::*;
	import tc_types_pkg::*;
(
	input  logic     clk,
	input  logic     resetn,
	input  logic     gpio_in_i,               // serial bit entering at the lsb
	input  logic     gpio_scan_i,
	input  logic     la_in_load_i,
	input  instr_t   la_data_i,
	input  logic     capture_i,               // gpio or la capture request
	input  bank_rd_t bank_rd_i [N_BANKS],
	output instr_t   instr_o
);

	instr_t   instr_q;
	reg_op_e  op;
	bank_rd_t rd_sel;  // read words of the selected bank

	// scan wins over load and load wins over capture
	always_comb begin
		if (gpio_scan_i) begin
			op = OP_SHIFT;
		end else if (la_in_load_i) begin
			op = OP_LOAD;
		end else if (capture_i) begin
			op = OP_CAPTURE;
		end else begin
			op = OP_HOLD;
		end
	end

	// bank read-back mux
	always_comb begin
		rd_sel = bank_rd_i[instr_q.sel];
		if (instr_q.sel == SEL_W'(ROM_BANK)) begin
			rd_sel.rd1 = '0;  // rom has no second port
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			instr_q <= '0;  // all port enables off
		end else begin
			case (op)
				OP_SHIFT: begin
					instr_q <= {instr_q[TOTAL_W-2:0], gpio_in_i};  // toward msb
				end
				OP_LOAD: begin
					instr_q <= la_data_i;
				end
				OP_CAPTURE: begin
					// only din fields change
					instr_q.port0.din <= rd_sel.rd0;
					instr_q.port1.din <= rd_sel.rd1;
				end
				default: begin
					instr_q <= instr_q;
				end
			endcase
		end
	end

	assign instr_o = instr_q;

	// a capture leaves sel, addr, en, web and wmask of both ports alone
	ap_capture_keeps_ctrl: assert property (@(posedge clk) disable iff (!resetn)
		(op == OP_CAPTURE) |=> (((instr_q ^ $past(instr_q)) & ~DIN_MASK) == '0))
		else $error("capture changed a field outside din");

endmodule

// File: src/tc_types_pkg.sv
package tc_types_pkg;
	import tc_geom_pkg::*;

	// one SRAM port command, MSB first
	typedef struct packed {
		logic [ADDR_W-1:0]  addr;
		logic [DATA_W-1:0]  din;    // write data, or captured read data
		logic               en;     // active high, decoded into the bank csb
		logic               web;    // active low write
		logic [WMASK_W-1:0] wmask;
	} port_req_t;

	// full instruction word as held in the scan register
	typedef struct packed {
		logic [SEL_W-1:0] sel;    // bank index, shared by both ports
		port_req_t        port0;
		port_req_t        port1;  // lsb of the word is port1 wmask[0]
	} instr_t;

	// read words coming back from one bank
	typedef struct packed {
		logic [DATA_W-1:0] rd0;  // port0 dout
		logic [DATA_W-1:0] rd1;  // port1 dout
	} bank_rd_t;

	// register update picked on each clock edge
	typedef enum logic [1:0] {
		OP_HOLD    = 2'd0,
		OP_SHIFT   = 2'd1,  // serial in from gpio
		OP_LOAD    = 2'd2,  // parallel in from la
		OP_CAPTURE = 2'd3   // read data into the din fields
	} reg_op_e;

endpackage

// File: src/tc_geom_pkg.sv
package tc_geom_pkg;

	// SRAM port field widths
	localparam int ADDR_W  = 16;
	localparam int DATA_W  = 32;
	localparam int WMASK_W = 4;    // byte mask for a 32 bit word
	localparam int SEL_W   = 4;    // bank index

	localparam int N_BANKS  = 16;
	localparam int ROM_BANK = 11;  // read only bank with a single read word

	// addr + din + wmask + web + en
	localparam int PORT_W  = ADDR_W + DATA_W + WMASK_W + 2;
	localparam int TOTAL_W = SEL_W + 2 * PORT_W;

	// bit positions of the din fields inside the full word
	localparam int DIN_OFS  = WMASK_W + 2;       // din sits above en, web and wmask
	localparam int DIN1_LSB = DIN_OFS;           // port1 is the low half
	localparam int DIN0_LSB = PORT_W + DIN_OFS;

	// ones over both din fields, everything else zero
	localparam logic [TOTAL_W-1:0] DIN_ONES = TOTAL_W'({DATA_W{1'b1}});
	localparam logic [TOTAL_W-1:0] DIN_MASK = (DIN_ONES << DIN0_LSB)
		| (DIN_ONES << DIN1_LSB);

endpackage
